// ==== verilog/tdc_defines.svh ====
// sizing macros for the TDC channel, included by the package and by every RTL file that sizes ports
`ifndef TDC_DEFINES_SVH
`define TDC_DEFINES_SVH

// taps in the sampled delay line
`define TDC_TAPS 96

// taps per coarse group in the encoder
// TDC_TAPS must be a multiple of this
`define TDC_GROUP 6

// coarse counter width in bits
`define COARSE_WIDTH 16

// default event buffer depth
// power of two, at least 2
`define FIFO_DEPTH 4

`endif

// ==== verilog/tdc_pkg.sv ====
// shared timestamp types and readout state encoding, imported by the TDC channel RTL
`include "tdc_defines.svh"

package tdc_pkg;

  // coarse timestamp in clock cycles
  typedef logic [`COARSE_WIDTH-1:0] coarse_t;

  // fine position inside the delay line
  // 7 bits hold 0 to 95
  typedef logic [$clog2(`TDC_TAPS)-1:0] fine_t;

  // four-phase readout states
  // idle: output side free, may load a new event
  // req_high: data presented, waiting for ack
  // wait_ack_low: req dropped, waiting for ack to return low
  typedef enum logic [1:0] {
    idle         = 2'd0,
    req_high     = 2'd1,
    wait_ack_low = 2'd2
  } readout_state_t;

endpackage

// ==== verilog/tdc_event_if.sv ====
// valid/ready event channel carrying one timestamped hit between the channel blocks
`timescale 1ns/10ps

interface tdc_event_if;
  import tdc_pkg::*;

  // event offered by the source
  logic    valid;
  // sink can take the event this cycle
  logic    ready;
  // payload
  coarse_t coarse;
  fine_t   fine;

  // transfer on a rising CLK edge with valid and ready both high

  modport source (
    output valid,
    output coarse,
    output fine,
    input  ready
  );

  modport sink (
    input  valid,
    input  coarse,
    input  fine,
    output ready
  );

endinterface

// ==== verilog/priority_encoder.sv ====
// pipelined thermometer-to-binary encoder for the sampled delay line, used inside hit_stamper
`timescale 1ns/10ps
`include "tdc_defines.svh"

module priority_encoder (
  input  logic                 CLK,
  input  logic                 arst_n,
  input  logic [`TDC_TAPS-1:0] sample,
  input  logic                 sample_valid,
  output tdc_pkg::fine_t       position,
  output logic                 position_valid
);
  import tdc_pkg::*;

  localparam int GROUPS = `TDC_TAPS / `TDC_GROUP;
  // two groups wide, so a bubble next to the edge still lands inside
  localparam int WINDOW = 2 * `TDC_GROUP;
  // zero padding lets the window start at the last group
  localparam int EXT_W  = `TDC_TAPS + WINDOW;
  localparam int IDX_W  = $clog2(GROUPS);
  localparam int CNT_W  = $clog2(WINDOW + 1);
  localparam int STAGES = 4;

  // marks the last full group, one bit per group boundary
  function automatic logic [GROUPS-2:0] therm2onehot(input logic [GROUPS-1:0] thermo);
    logic [GROUPS-2:0] onehot;
    for (int i = 0; i < GROUPS - 1; i++) begin
      onehot[i] = thermo[i] & ~thermo[i+1];
    end
    return onehot;
  endfunction

  // index of the first group that is not full
  // no full group at all gives 0
  function automatic logic [IDX_W-1:0] onehot2bin(input logic [GROUPS-2:0] onehot);
    logic [IDX_W-1:0] idx;
    idx = '0;
    for (int i = 0; i < GROUPS - 1; i++) begin
      if (onehot[i]) begin
        idx = IDX_W'(i + 1);
      end
    end
    return idx;
  endfunction

  // ones in the window, tolerates bubbles
  function automatic logic [CNT_W-1:0] ones_count(input logic [WINDOW-1:0] code);
    logic [CNT_W-1:0] cnt;
    cnt = '0;
    for (int i = 0; i < WINDOW; i++) begin
      cnt = cnt + CNT_W'(code[i]);
    end
    return cnt;
  endfunction

  // stage 1
  logic [GROUPS-1:0] coarse_code;
  logic [EXT_W-1:0]  bins_ext;
  // stage 2
  logic [IDX_W-1:0]  group_idx;
  logic [EXT_W-1:0]  bins_dly;
  // stage 3
  logic [IDX_W-1:0]  group_idx_dly;
  logic [WINDOW-1:0] window;
  // valid travels beside the data
  logic [STAGES-1:0] valid_sr;

  // datapath, no reset
  always_ff @(posedge CLK) begin
    // full groups as a coarse thermometer
    for (int g = 0; g < GROUPS; g++) begin
      coarse_code[g] <= &sample[g*`TDC_GROUP +: `TDC_GROUP];
    end
    bins_ext <= {{WINDOW{1'b0}}, sample};
    // group index of the transition
    group_idx <= onehot2bin(therm2onehot(coarse_code));
    bins_dly  <= bins_ext;
    // cut out the region around the transition
    group_idx_dly <= group_idx;
    window        <= bins_dly[group_idx*`TDC_GROUP +: WINDOW];
    // group base plus the ones inside the window
    position <= fine_t'(group_idx_dly * `TDC_GROUP) + fine_t'(ones_count(window));
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= {valid_sr[STAGES-2:0], sample_valid};
    end
  end

  assign position_valid = valid_sr[STAGES-1];

endmodule

// ==== verilog/hit_stamper.sv ====
// event producer: stamps each hit with the coarse counter and its encoded fine position
`timescale 1ns/10ps
`include "tdc_defines.svh"

module hit_stamper (
  input  logic                 CLK,
  input  logic                 arst_n,
  input  logic [`TDC_TAPS-1:0] sample,
  input  logic                 hit,
  tdc_event_if.source          ev,
  output logic [7:0]           lost_count
);
  import tdc_pkg::*;

  // must match the encoder latency
  localparam int STAGES = 4;
  localparam logic [7:0] LOST_MAX = 8'hff;

  coarse_t coarse_cnt;
  // timestamp delay line, aligned with the encoder pipeline
  coarse_t stamp_dly [STAGES];
  fine_t   position;
  logic    position_valid;
  // event offered while the buffer is full
  logic    drop;

  // free running, wraps
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      coarse_cnt <= '0;
    end else begin
      coarse_cnt <= coarse_cnt + 1'b1;
    end
  end

  // counter value at the hit edge enters here
  // shifts every cycle, the valid bit marks the real ones
  always_ff @(posedge CLK) begin
    stamp_dly[0] <= coarse_cnt;
    for (int i = 1; i < STAGES; i++) begin
      stamp_dly[i] <= stamp_dly[i-1];
    end
  end

  priority_encoder enc_i (
    .CLK            (CLK),
    .arst_n         (arst_n),
    .sample         (sample),
    .sample_valid   (hit),
    .position       (position),
    .position_valid (position_valid)
  );

  // offered once, never held back
  assign ev.valid  = position_valid;
  assign ev.coarse = stamp_dly[STAGES-1];
  assign ev.fine   = position;

  assign drop = ev.valid & ~ev.ready;

  // lost events, saturating
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      lost_count <= '0;
    end else if (drop && lost_count != LOST_MAX) begin
      lost_count <= lost_count + 1'b1;
    end
  end

endmodule

// ==== verilog/event_fifo.sv ====
// circular event buffer between the stamper and the readout, shows the oldest event at its output
`timescale 1ns/10ps
`include "tdc_defines.svh"

module event_fifo #(
  // power of two, at least 2
  parameter int DEPTH = `FIFO_DEPTH
) (
  input  logic        CLK,
  input  logic        arst_n,
  tdc_event_if.sink   wr,
  tdc_event_if.source rd
);
  import tdc_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);

  // storage
  coarse_t mem_coarse [DEPTH];
  fine_t   mem_fine   [DEPTH];

  // pointers wrap on their own
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // one extra bit to tell full from empty
  logic [PTR_W:0]   fill;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;

  assign full  = (fill == (PTR_W+1)'(DEPTH));
  assign empty = (fill == '0);
  assign push  = wr.valid & wr.ready;
  assign pop   = rd.valid & rd.ready;

  always_ff @(posedge CLK) begin
    if (push) begin
      mem_coarse[wr_ptr] <= wr.coarse;
      mem_fine[wr_ptr]   <= wr.fine;
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves the fill level alone
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  // write side
  assign wr.ready = ~full;

  // oldest entry, valid whenever not empty
  assign rd.valid  = ~empty;
  assign rd.coarse = mem_coarse[rd_ptr];
  assign rd.fine   = mem_fine[rd_ptr];

endmodule

// ==== verilog/readout_handshake.sv ====
// event consumer: presents buffered events on a four-phase req/ack output
`timescale 1ns/10ps

module readout_handshake (
  input  logic             CLK,
  input  logic             arst_n,
  tdc_event_if.sink        ev,
  output logic             req,
  input  logic             ack,
  output tdc_pkg::coarse_t coarse_out,
  output tdc_pkg::fine_t   fine_out
);
  import tdc_pkg::*;

  readout_state_t state;
  readout_state_t state_nxt;
  // event popped from the buffer this cycle
  logic           take;

  // only take new data while the output side is free
  assign ev.ready = (state == idle);
  assign take     = ev.valid & ev.ready;

  // req follows the state register directly
  // rises on the same edge as the new data
  assign req = (state == req_high);

  always_comb begin
    state_nxt = state;
    case (state)
      idle: begin
        if (ev.valid) begin
          state_nxt = req_high;
        end
      end
      req_high: begin
        // receiver has the data
        if (ack) begin
          state_nxt = wait_ack_low;
        end
      end
      wait_ack_low: begin
        // end of the four-phase cycle
        if (!ack) begin
          state_nxt = idle;
        end
      end
      default: begin
        state_nxt = idle;
      end
    endcase
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state <= idle;
    end else begin
      state <= state_nxt;
    end
  end

  // output data, held until the next take
  // stays put through req_high and wait_ack_low
  always_ff @(posedge CLK) begin
    if (take) begin
      coarse_out <= ev.coarse;
      fine_out   <= ev.fine;
    end
  end

endmodule

// ==== verilog/tdc_channel.sv ====
// top level of one TDC channel: stamper, event buffer and four-phase readout behind plain ports
`timescale 1ns/10ps
`include "tdc_defines.svh"

module tdc_channel (
  input  logic                                CLK,
  input  logic                                arst_n,
  // sampled thermometer code and its strobe
  input  logic [`TDC_TAPS-1:0]                sample,
  input  logic                                hit,
  // four-phase readout
  output logic                                req,
  input  logic                                ack,
  output logic [`COARSE_WIDTH-1:0]            coarse_out,
  output logic [$bits(tdc_pkg::fine_t)-1:0]   fine_out,
  // events dropped on a full buffer
  output logic [7:0]                          lost_count
);

  // stamper to buffer
  tdc_event_if stamp_if ();
  // buffer to readout
  tdc_event_if read_if ();

  // producer
  // drops events when the buffer is full
  hit_stamper stamper_i (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .sample     (sample),
    .hit        (hit),
    .ev         (stamp_if.source),
    .lost_count (lost_count)
  );

  // buffer
  event_fifo #(
    .DEPTH (`FIFO_DEPTH)
  ) fifo_i (
    .CLK    (CLK),
    .arst_n (arst_n),
    .wr     (stamp_if.sink),
    .rd     (read_if.source)
  );

  // consumer
  // holds one event on the outputs while the handshake runs
  readout_handshake readout_i (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .ev         (read_if.sink),
    .req        (req),
    .ack        (ack),
    .coarse_out (coarse_out),
    .fine_out   (fine_out)
  );

endmodule

// ==== test/tdc_channel_tb.sv ====
// directed testbench for one TDC channel, run as top module tdc_channel_tb from the file list
`timescale 1ns/10ps
`include "tdc_defines.svh"

module tdc_channel_tb;

  // cycle budget per test, sized from the hits and handshakes each one runs
  localparam int RESET_CYC      = 10;
  localparam int SINGLE_CYC     = 5 * 40;
  localparam int RANDOM_CYC     = 20 * 16 + 60;
  localparam int BURST_CYC      = 80;
  localparam int OVERFLOW_CYC   = 120;
  localparam int TIMEOUT_CYCLES = 2 * (RESET_CYC + SINGLE_CYC + RANDOM_CYC + BURST_CYC
                                       + OVERFLOW_CYC);
  // longest wait for queued events to come out
  localparam int EVENT_WAIT     = 60;

  logic                     CLK;
  logic                     arst_n;
  logic [`TDC_TAPS-1:0]     sample;
  logic                     hit;
  logic                     req;
  logic                     ack;
  logic [`COARSE_WIDTH-1:0] coarse_out;
  logic [6:0]               fine_out;
  logic [7:0]               lost_count;

  // posedges since time 0, and the count when reset was released
  int cycle = 0;
  int reset_cycle = 0;
  int mismatch_count = 0;
  int protocol_errors = 0;
  int other_errors = 0;

  // receiver control
  bit ack_enable = 1'b1;
  int ack_delay = 2;

  logic [31:0] lfsr_state = 32'h8d8e_da21;

  // expected events in hit order, collected events in req order
  logic [`COARSE_WIDTH-1:0] exp_coarse[$];
  int                       exp_fine[$];
  int                       hit_cycle[$];
  logic [`COARSE_WIDTH-1:0] got_coarse[$];
  int                       got_fine[$];

  // previous sample for the handshake monitor
  logic                     prev_req = 1'b0;
  logic                     prev_ack = 1'b0;
  logic [`COARSE_WIDTH-1:0] prev_coarse;
  logic [6:0]               prev_fine;

  tdc_channel dut_i (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .sample     (sample),
    .hit        (hit),
    .req        (req),
    .ack        (ack),
    .coarse_out (coarse_out),
    .fine_out   (fine_out),
    .lost_count (lost_count)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle = cycle + 1;
  end

  // 32-bit fibonacci, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit taken
  task automatic random_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = (value << 1) | lfsr_state[0];
    end
  endtask

  // ones in taps 0 to n-1
  function automatic logic [`TDC_TAPS-1:0] thermometer(input int n);
    logic [`TDC_TAPS-1:0] code;
    code = '0;
    for (int i = 0; i < n; i++) begin
      code[i] = 1'b1;
    end
    return code;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      mismatch_count++;
      $display("mismatch at %0t: %s, got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic settle(input int n);
    repeat (n) @(negedge CLK);
  endtask

  // one-cycle hit, called right after a falling edge
  // the counter holds cycle - reset_cycle at the sampling edge
  task automatic send_hit(input int n);
    sample = thermometer(n);
    hit    = 1'b1;
    exp_coarse.push_back(`COARSE_WIDTH'(cycle - reset_cycle));
    exp_fine.push_back(n);
    hit_cycle.push_back(cycle);
    @(negedge CLK);
    hit    = 1'b0;
    sample = '0;
  endtask

  task automatic wait_events(input int n);
    int waited;
    waited = 0;
    while (got_fine.size() < n && waited < EVENT_WAIT) begin
      @(negedge CLK);
      waited++;
    end
    if (got_fine.size() < n) begin
      other_errors++;
      $display("only %0d of %0d events came out within %0d cycles at %0t",
               got_fine.size(), n, EVENT_WAIT, $time);
    end
  endtask

  // in-order compare, then empties both sides
  task automatic compare_events(input string label);
    int n;
    check_value(got_fine.size(), exp_fine.size(), {label, " event count"});
    n = (got_fine.size() < exp_fine.size()) ? got_fine.size() : exp_fine.size();
    for (int i = 0; i < n; i++) begin
      check_value(got_fine[i], exp_fine[i], $sformatf("%s event %0d fine", label, i));
      check_value(got_coarse[i], exp_coarse[i], $sformatf("%s event %0d coarse", label, i));
    end
    got_fine.delete();
    got_coarse.delete();
    exp_fine.delete();
    exp_coarse.delete();
    hit_cycle.delete();
  endtask

  // receiver side of the four-phase handshake
  task automatic answer_req;
    @(negedge CLK);
    if (ack_enable && req && !ack) begin
      repeat (ack_delay) @(negedge CLK);
      ack = 1'b1;
    end else if (ack && !req) begin
      // ack lingers a while after req falls
      repeat (ack_delay) @(negedge CLK);
      ack = 1'b0;
    end
  endtask

  initial begin
    forever answer_req();
  end

  // sees the values held through the cycle before each rising edge
  always @(posedge CLK) begin
    if (arst_n) begin
      if (req && !prev_req) begin
        // ack as seen on the edge that raised req
        if (prev_ack) begin
          protocol_errors++;
          $display("handshake error at %0t: req rose while ack was still high", $time);
        end
        got_coarse.push_back(coarse_out);
        got_fine.push_back(fine_out);
      end
      if (req && prev_req && (coarse_out !== prev_coarse || fine_out !== prev_fine)) begin
        protocol_errors++;
        $display("handshake error at %0t: output data changed while req was high", $time);
      end
    end
    prev_req    = req;
    prev_ack    = ack;
    prev_coarse = coarse_out;
    prev_fine   = fine_out;
  end

  // edge lengths, one event at a time
  task automatic run_single_hits;
    int lengths[5] = '{0, 6, 8, 90, 95};
    foreach (lengths[i]) begin
      send_hit(lengths[i]);
      wait_events(1);
      settle(12);
      compare_events($sformatf("single N=%0d", lengths[i]));
    end
  endtask

  // spaced at least 8 cycles apart, longer than one readout cycle
  task automatic run_random_hits;
    int len;
    int gap;
    logic [`COARSE_WIDTH-1:0] d_got;
    logic [`COARSE_WIDTH-1:0] d_exp;
    for (int i = 0; i < 20; i++) begin
      random_bits(7, len);
      send_hit(len % 96);
      random_bits(3, gap);
      settle(gap + 7);
    end
    wait_events(20);
    settle(12);
    for (int i = 1; i < got_coarse.size() && i < hit_cycle.size(); i++) begin
      d_got = got_coarse[i] - got_coarse[i-1];
      d_exp = `COARSE_WIDTH'(hit_cycle[i] - hit_cycle[i-1]);
      check_value(d_got, d_exp, $sformatf("random coarse step %0d", i));
    end
    compare_events("random");
    check_value(lost_count, 0, "lost_count after random hits");
  endtask

  // hits on consecutive edges, ack answered at once
  task automatic run_burst;
    int len;
    ack_delay = 0;
    for (int i = 0; i < 5; i++) begin
      random_bits(7, len);
      send_hit(len % 96);
    end
    wait_events(5);
    settle(12);
    for (int i = 1; i < got_coarse.size(); i++) begin
      check_value(got_coarse[i] - got_coarse[i-1], 1, $sformatf("burst coarse step %0d", i));
    end
    compare_events("burst");
    check_value(lost_count, 0, "lost_count after burst");
    ack_delay = 2;
  endtask

  // readout holds one, buffer takes four, the last two are dropped
  task automatic run_overflow;
    ack_enable = 1'b0;
    for (int i = 0; i < 7; i++) begin
      send_hit(10 * i + 5);
    end
    settle(12);
    check_value(got_fine.size(), 1, "events out while ack held low");
    check_value(lost_count, 2, "lost_count with ack held low");
    void'(exp_fine.pop_back());
    void'(exp_fine.pop_back());
    void'(exp_coarse.pop_back());
    void'(exp_coarse.pop_back());
    ack_enable = 1'b1;
    wait_events(5);
    settle(12);
    compare_events("overflow");
    check_value(lost_count, 2, "lost_count after overflow drain");
  endtask

  initial begin
    arst_n = 1'b0;
    hit    = 1'b0;
    sample = '0;
    ack    = 1'b0;
    repeat (3) @(negedge CLK);
    arst_n      = 1'b1;
    reset_cycle = cycle;
    check_value(req, 0, "req after reset");
    check_value(lost_count, 0, "lost_count after reset");
    settle(2);
    run_single_hits();
    run_random_hits();
    run_burst();
    run_overflow();
    $display("errors: %0d mismatches, %0d handshake, %0d other",
             mismatch_count, protocol_errors, other_errors);
    if (mismatch_count + protocol_errors + other_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // run limit
  initial begin
    while (cycle < TIMEOUT_CYCLES) begin
      @(posedge CLK);
    end
    $display("run stopped after %0d cycles without finishing the tests", TIMEOUT_CYCLES);
    $display("errors: %0d mismatches, %0d handshake, %0d other",
             mismatch_count, protocol_errors, other_errors + 1);
    $display("Test failed");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+verilog
verilog/tdc_pkg.sv
verilog/tdc_event_if.sv
verilog/priority_encoder.sv
verilog/hit_stamper.sv
verilog/event_fifo.sv
verilog/readout_handshake.sv
verilog/tdc_channel.sv
test/tdc_channel_tb.sv
